//--- test/vdma_input.txt
// Channel lines: base stride width height frames (hex, width and height in pixels)
// Last line: start address of the burst that gets a SLVERR response
00010000 00000100 00000050 00000003 00000002
00020f80 000000c0 00000088 00000002 00000002
00010140

//--- sim.f
+incdir+rtl
rtl/vdma_frame_pkg.sv
rtl/vdma_axi_pkg.sv
rtl/stream_demux.sv
rtl/line_fifo.sv
rtl/frame_writer.sv
rtl/axi_write_arbiter.sv
rtl/vdma_write_top.sv
test/axi_mem_model.sv
test/tb_vdma_write.sv

//--- Bender.yml
package:
  name: vdma_write

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vdma_frame_pkg.sv
      - rtl/vdma_axi_pkg.sv
      - rtl/stream_demux.sv
      - rtl/line_fifo.sv
      - rtl/frame_writer.sv
      - rtl/axi_write_arbiter.sv
      - rtl/vdma_write_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/axi_mem_model.sv
      - test/tb_vdma_write.sv

//--- test/tb_vdma_write.sv
/*
 * Testbench for the multi-channel frame writer
 * Channel setup from a data file, pixel stream with random gaps and
 * interleaving, checks on every burst, frame_done, write_resp_error
 * and the final memory image
 */
`timescale 1ns/1ns
`default_nettype none
`include "vdma_macros.svh"

module tb_vdma_write;

	localparam int N = `VDMA_CHANNELS;
	localparam int BYTES = `VDMA_DATA_W / 8;

	// One expected burst, held in AW order until its last W beat
	typedef struct packed {
		logic [7:0] len;
		logic [7:0] chan;
		logic [7:0] frame;
		logic [11:0] row;
		logic [11:0] col;
	} burst_rec_t;

	logic M_AXI_ACLK;
	logic M_AXI_ARESETN;
	vdma_frame_pkg::pix_beat_t pix_in;
	logic pix_valid;
	logic pix_ready;
	vdma_frame_pkg::frame_cfg_t cfg [N];
	logic [N-1:0] frame_done;
	logic write_resp_error;
	vdma_axi_pkg::axi_addr_t M_AXI_AWADDR;
	vdma_axi_pkg::burst_len_t M_AXI_AWLEN;
	logic [2:0] M_AXI_AWSIZE;
	logic [1:0] M_AXI_AWBURST;
	logic M_AXI_AWVALID;
	logic M_AXI_AWREADY;
	logic [`VDMA_DATA_W-1:0] M_AXI_WDATA;
	logic [`VDMA_DATA_W/8-1:0] M_AXI_WSTRB;
	logic M_AXI_WLAST;
	logic M_AXI_WVALID;
	logic M_AXI_WREADY;
	vdma_axi_pkg::b_resp_t M_AXI_BRESP;
	logic M_AXI_BVALID;
	logic M_AXI_BREADY;
	logic aw_stall;
	logic w_stall;
	logic b_stall;

	// Setup from the stimulus file
	logic [31:0] file_words [0:5*N];
	int frame_cnt [N];
	int total_words [N];
	vdma_axi_pkg::axi_addr_t err_addr;
	int total_beats;
	int cycle_limit;

	// Stimulus state
	logic [31:0] rng;
	int sent [N];
	logic pix_taken;
	logic stream_on;
	int pick;
	int idx;

	// Scoreboard
	int exp_frame [N];
	int exp_row [N];
	int exp_col [N];
	int done_cnt [N];
	logic [N-1:0] done_prev;
	int exp_err;
	int err_seen;
	logic err_prev;
	burst_rec_t burst_q [$];
	burst_rec_t rec;
	int w_beat;
	int cycles;
	int mismatch_cnt;
	int fault_cnt;
	int ch;
	int rw;
	int exp_len;
	vdma_axi_pkg::axi_addr_t exp_addr;
	logic [31:0] exp_data;

	vdma_write_top uut (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.pix_in(pix_in),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready),
		.cfg(cfg),
		.frame_done(frame_done),
		.write_resp_error(write_resp_error),
		.M_AXI_AWADDR(M_AXI_AWADDR),
		.M_AXI_AWLEN(M_AXI_AWLEN),
		.M_AXI_AWSIZE(M_AXI_AWSIZE),
		.M_AXI_AWBURST(M_AXI_AWBURST),
		.M_AXI_AWVALID(M_AXI_AWVALID),
		.M_AXI_AWREADY(M_AXI_AWREADY),
		.M_AXI_WDATA(M_AXI_WDATA),
		.M_AXI_WSTRB(M_AXI_WSTRB),
		.M_AXI_WLAST(M_AXI_WLAST),
		.M_AXI_WVALID(M_AXI_WVALID),
		.M_AXI_WREADY(M_AXI_WREADY),
		.M_AXI_BRESP(M_AXI_BRESP),
		.M_AXI_BVALID(M_AXI_BVALID),
		.M_AXI_BREADY(M_AXI_BREADY)
	);

	axi_mem_model u_mem (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.awaddr(M_AXI_AWADDR),
		.awvalid(M_AXI_AWVALID),
		.awready(M_AXI_AWREADY),
		.wdata(M_AXI_WDATA),
		.wlast(M_AXI_WLAST),
		.wvalid(M_AXI_WVALID),
		.wready(M_AXI_WREADY),
		.bresp(M_AXI_BRESP),
		.bvalid(M_AXI_BVALID),
		.bready(M_AXI_BREADY),
		.err_addr(err_addr),
		.aw_stall(aw_stall),
		.w_stall(w_stall),
		.b_stall(b_stall)
	);

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Channel in the top byte, then frame, row, word column
	function automatic logic [31:0] pixel_rule(input int c, input int f, input int r, input int w);
		return {8'(c), 8'(f), 8'(r), 8'(w)};
	endfunction

	function automatic int words_per_row(input int c);
		return int'(cfg[c].width) / `VDMA_PIX_PER_WORD;
	endfunction

	// Word number i of a channel's whole stream
	function automatic logic [31:0] stream_word(input int c, input int i);
		int per_frame;
		per_frame = words_per_row(c) * int'(cfg[c].height);
		return pixel_rule(c, i / per_frame, (i % per_frame) / words_per_row(c),
			i % words_per_row(c));
	endfunction

	function automatic int chan_of_addr(input vdma_axi_pkg::axi_addr_t a);
		int found;
		found = -1;
		for (int c = 0; c < N; c++) begin
			if (a >= cfg[c].base && a < cfg[c].base + cfg[c].height * cfg[c].stride) begin
				found = c;
			end
		end
		return found;
	endfunction

	function automatic logic all_frames_done();
		logic done;
		done = 1'b1;
		for (int c = 0; c < N; c++) begin
			if (done_cnt[c] < frame_cnt[c]) begin
				done = 1'b0;
			end
		end
		return done;
	endfunction

	task automatic show_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
		mismatch_cnt++;
	endtask

	task automatic count_fault(input string msg);
		$display("Error: %s", msg);
		fault_cnt++;
	endtask

	// Last frame of every channel must sit in memory, nothing else
	task automatic check_memory();
		vdma_axi_pkg::axi_addr_t a;
		logic [31:0] want;
		int expected_words;
		expected_words = 0;
		for (int c = 0; c < N; c++) begin
			for (int r = 0; r < int'(cfg[c].height); r++) begin
				for (int w = 0; w < words_per_row(c); w++) begin
					a = cfg[c].base + r * cfg[c].stride + w * BYTES;
					want = pixel_rule(c, frame_cnt[c] - 1, r, w);
					expected_words++;
					if (!u_mem.has_word(a)) begin
						count_fault($sformatf("no write reached address 0x%08h", a));
					end else if (u_mem.read_word(a) !== want) begin
						show_mismatch($sformatf("mem[0x%08h]", a), u_mem.read_word(a), want);
					end
				end
			end
		end
		if (u_mem.word_count() != expected_words) begin
			show_mismatch("written word count", u_mem.word_count(), expected_words);
		end
	endtask

	// ------------------------------------------------------------------
	// Clock, setup and end of run
	// ------------------------------------------------------------------

	initial begin
		M_AXI_ACLK = 1'b0;
		forever #2 M_AXI_ACLK = ~M_AXI_ACLK;
	end

	initial begin
		M_AXI_ARESETN = 1'b0;
		pix_in = '0;
		pix_valid = 1'b0;
		pix_taken = 1'b0;
		stream_on = 1'b0;
		aw_stall = 1'b0;
		w_stall = 1'b0;
		b_stall = 1'b0;
		rng = 32'hda14_3dcd;
		w_beat = 0;
		exp_err = 0;
		err_seen = 0;
		err_prev = 1'b0;
		done_prev = '0;
		total_beats = 0;
		$readmemh("test/vdma_input.txt", file_words);
		for (int c = 0; c < N; c++) begin
			cfg[c].base = file_words[5*c];
			cfg[c].stride = file_words[5*c+1];
			cfg[c].width = file_words[5*c+2][11:0];
			cfg[c].height = file_words[5*c+3][11:0];
			frame_cnt[c] = int'(file_words[5*c+4]);
			total_words[c] = words_per_row(c) * int'(cfg[c].height) * frame_cnt[c];
			total_beats += total_words[c];
			sent[c] = 0;
			exp_frame[c] = 0;
			exp_row[c] = 0;
			exp_col[c] = 0;
			done_cnt[c] = 0;
		end
		err_addr = file_words[5*N];
		if ($isunknown(err_addr)) begin
			count_fault("stimulus file test/vdma_input.txt is missing or short");
			cycle_limit = 2000;
		end else begin
			cycle_limit = 40 * total_beats + 2000;
		end

		repeat (4) @(posedge M_AXI_ACLK);
		@(negedge M_AXI_ACLK);
		// Quiet outputs out of reset
		if (M_AXI_AWVALID !== 1'b0) begin
			show_mismatch("M_AXI_AWVALID", M_AXI_AWVALID, 0);
		end
		if (M_AXI_WVALID !== 1'b0) begin
			show_mismatch("M_AXI_WVALID", M_AXI_WVALID, 0);
		end
		if (M_AXI_BREADY !== 1'b0) begin
			show_mismatch("M_AXI_BREADY", M_AXI_BREADY, 0);
		end
		if (frame_done !== '0) begin
			show_mismatch("frame_done", frame_done, 0);
		end
		if (write_resp_error !== 1'b0) begin
			show_mismatch("write_resp_error", write_resp_error, 0);
		end
		M_AXI_ARESETN = 1'b1;

		while (!all_frames_done()) @(negedge M_AXI_ACLK);
		repeat (20) @(negedge M_AXI_ACLK);
		check_memory();
		for (int c = 0; c < N; c++) begin
			if (done_cnt[c] != frame_cnt[c]) begin
				show_mismatch($sformatf("frame_done[%0d] pulses", c), done_cnt[c], frame_cnt[c]);
			end
		end
		if (err_seen != exp_err) begin
			show_mismatch("write_resp_error pulses", err_seen, exp_err);
		end
		if (burst_q.size() != 0) begin
			count_fault("bursts left open without their last W beat");
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
		if (mismatch_cnt == 0 && fault_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// ------------------------------------------------------------------
	// Stimulus on the falling edge
	// ------------------------------------------------------------------

	always @(negedge M_AXI_ACLK) begin
		// Inputs stay quiet until reset is released
		if (stream_on === 1'b1) begin
			rng = xorshift(rng);
			aw_stall = (rng[1:0] == 2'd0);
			w_stall = (rng[4:2] < 3'd2);
			b_stall = (rng[7:5] < 3'd3);
			if (pix_taken) begin
				sent[int'(pix_in.chan)]++;
				pix_valid = 1'b0;
				pix_taken = 1'b0;
			end
			// About one idle cycle in eight
			if (!pix_valid && rng[10:8] != 3'd0) begin
				pick = -1;
				for (int k = 0; k < N; k++) begin
					idx = (int'(rng[15:12]) + k) % N;
					if (pick < 0 && sent[idx] < total_words[idx]) begin
						pick = idx;
					end
				end
				if (pick >= 0) begin
					pix_in.chan = vdma_frame_pkg::chan_id_t'(pick);
					pix_in.data = stream_word(pick, sent[pick]);
					pix_valid = 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// Bus monitor on the rising edge
	// ------------------------------------------------------------------

	always @(posedge M_AXI_ACLK) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: frames not finished after %0d cycles", cycles);
			$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
			$display("Simulation failed");
			$finish;
		end else if (M_AXI_ARESETN) begin
			stream_on = 1'b1;
			if (pix_valid && pix_ready) begin
				pix_taken = 1'b1;
			end

			if (M_AXI_AWVALID && M_AXI_AWREADY) begin
				ch = chan_of_addr(M_AXI_AWADDR);
				if (ch < 0) begin
					count_fault($sformatf("burst at 0x%08h lies outside every frame",
						M_AXI_AWADDR));
				end else begin
					rw = words_per_row(ch);
					exp_len = (rw - exp_col[ch] > `VDMA_BURST_LEN) ?
						`VDMA_BURST_LEN : rw - exp_col[ch];
					exp_addr = cfg[ch].base + exp_row[ch] * cfg[ch].stride + exp_col[ch] * BYTES;
					if (exp_frame[ch] >= frame_cnt[ch]) begin
						count_fault($sformatf("channel %0d wrote more frames than requested", ch));
					end
					if (M_AXI_AWADDR !== exp_addr) begin
						show_mismatch("M_AXI_AWADDR", M_AXI_AWADDR, exp_addr);
					end
					if (M_AXI_AWLEN !== 8'(exp_len - 1)) begin
						show_mismatch("M_AXI_AWLEN", M_AXI_AWLEN, exp_len - 1);
					end
					if (int'(M_AXI_AWADDR[11:0]) + (int'(M_AXI_AWLEN) + 1) * BYTES > 4096) begin
						count_fault($sformatf("burst at 0x%08h crosses a 4K boundary",
							M_AXI_AWADDR));
					end
					if (M_AXI_AWSIZE !== 3'd2) begin
						show_mismatch("M_AXI_AWSIZE", M_AXI_AWSIZE, 2);
					end
					if (M_AXI_AWBURST !== 2'b01) begin
						show_mismatch("M_AXI_AWBURST", M_AXI_AWBURST, 1);
					end
					if (exp_addr == err_addr) begin
						exp_err++;
					end
					rec.len = 8'(exp_len - 1);
					rec.chan = 8'(ch);
					rec.frame = 8'(exp_frame[ch]);
					rec.row = 12'(exp_row[ch]);
					rec.col = 12'(exp_col[ch]);
					burst_q.push_back(rec);
					// Next burst of this channel
					exp_col[ch] += exp_len;
					if (exp_col[ch] == rw) begin
						exp_col[ch] = 0;
						exp_row[ch]++;
						if (exp_row[ch] == int'(cfg[ch].height)) begin
							exp_row[ch] = 0;
							exp_frame[ch]++;
						end
					end
				end
			end

			if (M_AXI_WVALID && M_AXI_WREADY) begin
				if (burst_q.size() == 0) begin
					count_fault("W beat accepted with no open burst");
				end else begin
					rec = burst_q[0];
					exp_data = pixel_rule(int'(rec.chan), int'(rec.frame), int'(rec.row),
						int'(rec.col) + w_beat);
					if (M_AXI_WDATA !== exp_data) begin
						show_mismatch("M_AXI_WDATA", M_AXI_WDATA, exp_data);
					end
					if (M_AXI_WLAST !== (w_beat == int'(rec.len))) begin
						show_mismatch("M_AXI_WLAST", M_AXI_WLAST, w_beat == int'(rec.len));
					end
					if (M_AXI_WSTRB !== '1) begin
						show_mismatch("M_AXI_WSTRB", M_AXI_WSTRB, 4'hf);
					end
					if (w_beat == int'(rec.len)) begin
						w_beat = 0;
						void'(burst_q.pop_front());
					end else begin
						w_beat++;
					end
				end
			end

			for (int c = 0; c < N; c++) begin
				if (frame_done[c]) begin
					done_cnt[c]++;
					if (done_prev[c]) begin
						count_fault($sformatf("frame_done[%0d] high for more than one cycle", c));
					end
					if (exp_row[c] != 0 || exp_col[c] != 0 || exp_frame[c] != done_cnt[c]) begin
						count_fault($sformatf("frame_done[%0d] before the frame's last burst", c));
					end
				end
			end
			done_prev = frame_done;

			if (write_resp_error) begin
				err_seen++;
				if (err_prev) begin
					count_fault("write_resp_error high for more than one cycle");
				end
			end
			err_prev = write_resp_error;
		end
	end

endmodule

`default_nettype wire

//--- test/axi_mem_model.sv
/*
 * AXI4 write slave memory for the testbench
 * Sparse word storage, stall inputs for ready and response timing,
 * SLVERR for the burst that starts at the error address
 */
`timescale 1ns/1ns
`default_nettype none
`include "vdma_macros.svh"

module axi_mem_model (
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,
	input wire vdma_axi_pkg::axi_addr_t awaddr,
	input wire awvalid,
	output logic awready,
	input wire [`VDMA_DATA_W-1:0] wdata,
	input wire wlast,
	input wire wvalid,
	output logic wready,
	output vdma_axi_pkg::b_resp_t bresp,
	output logic bvalid,
	input wire bready,
	input wire vdma_axi_pkg::axi_addr_t err_addr,
	input wire aw_stall,
	input wire w_stall,
	input wire b_stall
);

	localparam int BYTES = `VDMA_DATA_W / 8;

	logic [`VDMA_DATA_W-1:0] mem [vdma_axi_pkg::axi_addr_t];
	vdma_axi_pkg::axi_addr_t burst_q [$];
	vdma_axi_pkg::b_resp_t resp_q [$];
	vdma_axi_pkg::axi_addr_t cur;
	int pending;
	int beat;
	logic aw_hs;
	logic w_end;

	assign awready = !aw_stall;
	// W waits until its address has been taken
	assign wready = !w_stall && (pending != 0);

	always @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			pending <= 0;
			bvalid <= 1'b0;
			bresp <= 2'b00;
			beat = 0;
			burst_q.delete();
			resp_q.delete();
		end else begin
			aw_hs = awvalid && awready;
			w_end = wvalid && wready && wlast;
			if (aw_hs) begin
				burst_q.push_back(awaddr);
			end
			if (wvalid && wready) begin
				cur = burst_q[0];
				mem[cur + vdma_axi_pkg::axi_addr_t'(beat * BYTES)] = wdata;
				if (wlast) begin
					beat = 0;
					// Error address gets SLVERR, data is still stored
					resp_q.push_back((cur == err_addr) ? 2'b10 : 2'b00);
					void'(burst_q.pop_front());
				end else begin
					beat++;
				end
			end
			pending <= pending + int'(aw_hs) - int'(w_end);

			// Response held until taken
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end else if (!bvalid && resp_q.size() != 0 && !b_stall) begin
				bvalid <= 1'b1;
				bresp <= resp_q.pop_front();
			end
		end
	end

	function automatic logic has_word(input vdma_axi_pkg::axi_addr_t a);
		return mem.exists(a) != 0;
	endfunction

	function automatic logic [`VDMA_DATA_W-1:0] read_word(input vdma_axi_pkg::axi_addr_t a);
		return mem[a];
	endfunction

	function automatic int word_count();
		return mem.num();
	endfunction

endmodule

`default_nettype wire

//--- rtl/vdma_write_top.sv
/*
 * Multi-channel frame writer top
 * Demux, per-channel FIFO and writer pairs, AXI write arbiter
 */
`timescale 1ns/1ns
`default_nettype none
`include "vdma_macros.svh"

module vdma_write_top (
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,
	input wire vdma_frame_pkg::pix_beat_t pix_in,
	input wire pix_valid,
	output wire pix_ready,
	input wire vdma_frame_pkg::frame_cfg_t cfg [`VDMA_CHANNELS],
	output wire [`VDMA_CHANNELS-1:0] frame_done,
	output wire write_resp_error,
	output wire vdma_axi_pkg::axi_addr_t M_AXI_AWADDR,
	output wire vdma_axi_pkg::burst_len_t M_AXI_AWLEN,
	output wire [2:0] M_AXI_AWSIZE,
	output wire [1:0] M_AXI_AWBURST,
	output wire M_AXI_AWVALID,
	input wire M_AXI_AWREADY,
	output wire [`VDMA_DATA_W-1:0] M_AXI_WDATA,
	output wire [`VDMA_DATA_W/8-1:0] M_AXI_WSTRB,
	output wire M_AXI_WLAST,
	output wire M_AXI_WVALID,
	input wire M_AXI_WREADY,
	input wire vdma_axi_pkg::b_resp_t M_AXI_BRESP,
	input wire M_AXI_BVALID,
	output wire M_AXI_BREADY
);

	localparam int N = `VDMA_CHANNELS;

	vdma_frame_pkg::pixel_word_t fifo_in_data;
	logic [N-1:0] fifo_in_valid;
	logic [N-1:0] fifo_in_ready;
	vdma_frame_pkg::pixel_word_t rd_data [N];
	logic [N-1:0] rd_valid;
	logic [N-1:0] rd_ready;
	logic [$clog2(`VDMA_FIFO_DEPTH+1)-1:0] rd_count [N];
	vdma_axi_pkg::aw_req_t aw_req [N];
	logic [N-1:0] aw_valid;
	logic [N-1:0] aw_ready;
	vdma_axi_pkg::w_beat_t w_beat [N];
	logic [N-1:0] w_valid;
	logic [N-1:0] w_ready;
	logic [N-1:0] b_valid;
	vdma_axi_pkg::b_resp_t b_resp [N];
	logic [N-1:0] b_ready;

	stream_demux u_demux (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.pix_in(pix_in),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready),
		.fifo_in_data(fifo_in_data),
		.fifo_in_valid(fifo_in_valid),
		.fifo_in_ready(fifo_in_ready)
	);

	// One FIFO and writer per channel
	for (genvar c = 0; c < N; c++) begin : g_chan
		line_fifo u_fifo (
			.M_AXI_ACLK(M_AXI_ACLK),
			.M_AXI_ARESETN(M_AXI_ARESETN),
			.in_data(fifo_in_data),
			.in_valid(fifo_in_valid[c]),
			.in_ready(fifo_in_ready[c]),
			.out_data(rd_data[c]),
			.out_valid(rd_valid[c]),
			.out_ready(rd_ready[c]),
			.count(rd_count[c])
		);

		frame_writer u_writer (
			.M_AXI_ACLK(M_AXI_ACLK),
			.M_AXI_ARESETN(M_AXI_ARESETN),
			.cfg(cfg[c]),
			.rd_data(rd_data[c]),
			.rd_valid(rd_valid[c]),
			.rd_ready(rd_ready[c]),
			.rd_count(rd_count[c]),
			.aw_req(aw_req[c]),
			.aw_valid(aw_valid[c]),
			.aw_ready(aw_ready[c]),
			.w_beat(w_beat[c]),
			.w_valid(w_valid[c]),
			.w_ready(w_ready[c]),
			.b_valid(b_valid[c]),
			.b_resp(b_resp[c]),
			.b_ready(b_ready[c]),
			.frame_done(frame_done[c])
		);
	end

	axi_write_arbiter u_arbiter (
		.M_AXI_ACLK(M_AXI_ACLK),
		.M_AXI_ARESETN(M_AXI_ARESETN),
		.aw_req(aw_req),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w_beat(w_beat),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b_valid(b_valid),
		.b_resp(b_resp),
		.b_ready(b_ready),
		.M_AXI_AWADDR(M_AXI_AWADDR),
		.M_AXI_AWLEN(M_AXI_AWLEN),
		.M_AXI_AWSIZE(M_AXI_AWSIZE),
		.M_AXI_AWBURST(M_AXI_AWBURST),
		.M_AXI_AWVALID(M_AXI_AWVALID),
		.M_AXI_AWREADY(M_AXI_AWREADY),
		.M_AXI_WDATA(M_AXI_WDATA),
		.M_AXI_WSTRB(M_AXI_WSTRB),
		.M_AXI_WLAST(M_AXI_WLAST),
		.M_AXI_WVALID(M_AXI_WVALID),
		.M_AXI_WREADY(M_AXI_WREADY),
		.M_AXI_BRESP(M_AXI_BRESP),
		.M_AXI_BVALID(M_AXI_BVALID),
		.M_AXI_BREADY(M_AXI_BREADY),
		.write_resp_error(write_resp_error)
	);

endmodule

`default_nettype wire

//--- rtl/axi_write_arbiter.sv
/*
 * AXI write arbiter
 * Round-robin AW grant, W and B routed in grant order
 * through two small order queues
 */
`timescale 1ns/1ns
`default_nettype none
`include "vdma_macros.svh"

module axi_write_arbiter (
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,
	input wire vdma_axi_pkg::aw_req_t aw_req [`VDMA_CHANNELS],
	input wire [`VDMA_CHANNELS-1:0] aw_valid,
	output logic [`VDMA_CHANNELS-1:0] aw_ready,
	input wire vdma_axi_pkg::w_beat_t w_beat [`VDMA_CHANNELS],
	input wire [`VDMA_CHANNELS-1:0] w_valid,
	output logic [`VDMA_CHANNELS-1:0] w_ready,
	output logic [`VDMA_CHANNELS-1:0] b_valid,
	output vdma_axi_pkg::b_resp_t b_resp [`VDMA_CHANNELS],
	input wire [`VDMA_CHANNELS-1:0] b_ready,
	output vdma_axi_pkg::axi_addr_t M_AXI_AWADDR,
	output vdma_axi_pkg::burst_len_t M_AXI_AWLEN,
	output logic [2:0] M_AXI_AWSIZE,
	output logic [1:0] M_AXI_AWBURST,
	output logic M_AXI_AWVALID,
	input wire M_AXI_AWREADY,
	output logic [`VDMA_DATA_W-1:0] M_AXI_WDATA,
	output logic [`VDMA_DATA_W/8-1:0] M_AXI_WSTRB,
	output logic M_AXI_WLAST,
	output logic M_AXI_WVALID,
	input wire M_AXI_WREADY,
	input wire vdma_axi_pkg::b_resp_t M_AXI_BRESP,
	input wire M_AXI_BVALID,
	output logic M_AXI_BREADY,
	output logic write_resp_error
);

	localparam int N = `VDMA_CHANNELS;
	localparam int QD = 4;

	vdma_frame_pkg::chan_id_t rr_ptr;
	vdma_frame_pkg::chan_id_t pick;
	logic pick_found;
	logic grant;
	vdma_axi_pkg::aw_req_t aw_hold;

	// Queue 0 orders W, queue 1 orders B
	vdma_frame_pkg::chan_id_t q_mem [2][QD];
	logic [$clog2(QD)-1:0] q_wr [2];
	logic [$clog2(QD)-1:0] q_rd [2];
	logic [$clog2(QD+1)-1:0] q_cnt [2];
	logic [1:0] q_pop;
	vdma_frame_pkg::chan_id_t w_head;
	vdma_frame_pkg::chan_id_t b_head;
	logic w_active;
	logic b_active;
	logic w_hs;
	logic b_hs;

	// ------------------------------------------------------------------
	// AW grant
	// ------------------------------------------------------------------

	// First requester at or after the round-robin pointer
	always_comb begin
		int idx;
		pick = rr_ptr;
		pick_found = 1'b0;
		for (int k = N - 1; k >= 0; k--) begin
			idx = (int'(rr_ptr) + k) % N;
			if (aw_valid[idx]) begin
				pick = vdma_frame_pkg::chan_id_t'(idx);
				pick_found = 1'b1;
			end
		end
	end

	assign grant = pick_found && !M_AXI_AWVALID && (q_cnt[0] != QD) && (q_cnt[1] != QD);

	always_comb begin
		for (int c = 0; c < N; c++) begin
			aw_ready[c] = grant && (pick == vdma_frame_pkg::chan_id_t'(c));
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			M_AXI_AWVALID <= 1'b0;
			rr_ptr <= '0;
		end else if (grant) begin
			M_AXI_AWVALID <= 1'b1;
			rr_ptr <= vdma_frame_pkg::chan_id_t'((int'(pick) + 1) % N);
		end else if (M_AXI_AWREADY) begin
			M_AXI_AWVALID <= 1'b0;
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (grant) begin
			aw_hold <= aw_req[pick];
		end
	end

	assign M_AXI_AWADDR = aw_hold.addr;
	assign M_AXI_AWLEN = aw_hold.len;
	assign M_AXI_AWSIZE = 3'($clog2(`VDMA_DATA_W / 8));
	// INCR
	assign M_AXI_AWBURST = 2'b01;

	// ------------------------------------------------------------------
	// Order queues
	// ------------------------------------------------------------------

	assign q_pop[0] = w_hs && M_AXI_WLAST;
	assign q_pop[1] = b_hs;

	always_ff @(posedge M_AXI_ACLK) begin
		for (int q = 0; q < 2; q++) begin
			if (!M_AXI_ARESETN) begin
				q_wr[q] <= '0;
				q_rd[q] <= '0;
				q_cnt[q] <= '0;
			end else begin
				if (grant) begin
					q_mem[q][q_wr[q]] <= pick;
					q_wr[q] <= q_wr[q] + 1'b1;
				end
				if (q_pop[q]) begin
					q_rd[q] <= q_rd[q] + 1'b1;
				end
				if (grant && !q_pop[q]) begin
					q_cnt[q] <= q_cnt[q] + 1'b1;
				end else if (q_pop[q] && !grant) begin
					q_cnt[q] <= q_cnt[q] - 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// W and B routing
	// ------------------------------------------------------------------

	assign w_head = q_mem[0][q_rd[0]];
	assign b_head = q_mem[1][q_rd[1]];
	assign w_active = (q_cnt[0] != '0);
	assign b_active = (q_cnt[1] != '0);

	assign M_AXI_WVALID = w_active && w_valid[w_head];
	assign M_AXI_WDATA = w_beat[w_head].data;
	assign M_AXI_WLAST = w_beat[w_head].last;
	assign M_AXI_WSTRB = '1;
	assign M_AXI_BREADY = b_active && b_ready[b_head];

	assign w_hs = M_AXI_WVALID && M_AXI_WREADY;
	assign b_hs = M_AXI_BVALID && M_AXI_BREADY;

	always_comb begin
		for (int c = 0; c < N; c++) begin
			w_ready[c] = w_active && (w_head == vdma_frame_pkg::chan_id_t'(c)) && M_AXI_WREADY;
			b_valid[c] = b_active && (b_head == vdma_frame_pkg::chan_id_t'(c)) && M_AXI_BVALID;
			b_resp[c] = M_AXI_BRESP;
		end
	end

	// SLVERR and DECERR both have the top bit set
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			write_resp_error <= 1'b0;
		end else begin
			write_resp_error <= b_hs && M_AXI_BRESP[1];
		end
	end

endmodule

`default_nettype wire

//--- rtl/frame_writer.sv
/*
 * Per-channel frame writer
 * Cuts each image row into INCR bursts, one burst in flight,
 * and pulses frame_done after the last response of the frame
 */
`timescale 1ns/1ns
`default_nettype none
`include "vdma_macros.svh"

module frame_writer (
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,
	input wire vdma_frame_pkg::frame_cfg_t cfg,
	input wire vdma_frame_pkg::pixel_word_t rd_data,
	input wire rd_valid,
	output logic rd_ready,
	input wire [$clog2(`VDMA_FIFO_DEPTH+1)-1:0] rd_count,
	output vdma_axi_pkg::aw_req_t aw_req,
	output logic aw_valid,
	input wire aw_ready,
	output vdma_axi_pkg::w_beat_t w_beat,
	output logic w_valid,
	input wire w_ready,
	input wire b_valid,
	input wire vdma_axi_pkg::b_resp_t b_resp,
	output logic b_ready,
	output logic frame_done
);

	localparam int BYTE_SHIFT = $clog2(`VDMA_DATA_W / 8);
	localparam vdma_frame_pkg::img_dim_t FULL_WORDS = `VDMA_BURST_LEN;

	vdma_axi_pkg::writer_state_t state;
	vdma_axi_pkg::axi_addr_t cur_addr;
	vdma_axi_pkg::axi_addr_t line_addr;
	vdma_axi_pkg::burst_len_t burst_len;
	vdma_axi_pkg::burst_len_t beat_cnt;
	vdma_frame_pkg::img_dim_t col_left;
	vdma_frame_pkg::img_dim_t rows_left;
	vdma_frame_pkg::img_dim_t row_words;
	vdma_frame_pkg::img_dim_t next_words;
	logic row_end;
	logic frame_end;
	logic w_last;

	// ------------------------------------------------------------------
	// Frame geometry
	// ------------------------------------------------------------------

	assign row_words = cfg.width / `VDMA_PIX_PER_WORD;

	// Short tail burst when the row is not a multiple of the burst
	assign next_words = (col_left > FULL_WORDS) ? FULL_WORDS : col_left;
	assign row_end = (col_left == next_words);
	assign frame_end = row_end && (rows_left == vdma_frame_pkg::img_dim_t'(1));

	// Position moves on when the burst's response returns
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			cur_addr <= cfg.base;
			line_addr <= cfg.base;
			col_left <= row_words;
			rows_left <= cfg.height;
		end else if (state == vdma_axi_pkg::st_resp && b_valid) begin
			if (frame_end) begin
				// Wrap to the top of the next frame
				cur_addr <= cfg.base;
				line_addr <= cfg.base;
				col_left <= row_words;
				rows_left <= cfg.height;
			end else if (row_end) begin
				cur_addr <= line_addr + cfg.stride;
				line_addr <= line_addr + cfg.stride;
				col_left <= row_words;
				rows_left <= rows_left - 1'b1;
			end else begin
				cur_addr <= cur_addr + (vdma_axi_pkg::axi_addr_t'(next_words) << BYTE_SHIFT);
				col_left <= col_left - next_words;
			end
		end
	end

	// ------------------------------------------------------------------
	// Burst FSM
	// ------------------------------------------------------------------

	assign w_last = (beat_cnt == burst_len);

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			state <= vdma_axi_pkg::st_idle;
			burst_len <= '0;
			beat_cnt <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				vdma_axi_pkg::st_idle: begin
					// Start only once the whole burst sits in the FIFO
					if (vdma_frame_pkg::img_dim_t'(rd_count) >= next_words) begin
						burst_len <= vdma_axi_pkg::burst_len_t'(next_words - 1'b1);
						state <= vdma_axi_pkg::st_addr;
					end
				end
				vdma_axi_pkg::st_addr: begin
					if (aw_ready) begin
						beat_cnt <= '0;
						state <= vdma_axi_pkg::st_data;
					end
				end
				vdma_axi_pkg::st_data: begin
					if (w_valid && w_ready) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (w_last) begin
							state <= vdma_axi_pkg::st_resp;
						end
					end
				end
				vdma_axi_pkg::st_resp: begin
					// Error responses are reported upstream, the frame goes on
					if (b_valid) begin
						frame_done <= frame_end;
						state <= vdma_axi_pkg::st_idle;
					end
				end
				default: state <= vdma_axi_pkg::st_idle;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Channel outputs
	// ------------------------------------------------------------------

	assign aw_valid = (state == vdma_axi_pkg::st_addr);
	assign aw_req.addr = cur_addr;
	assign aw_req.len = burst_len;

	// W beats come straight out of the FIFO
	assign w_valid = (state == vdma_axi_pkg::st_data) && rd_valid;
	assign rd_ready = (state == vdma_axi_pkg::st_data) && w_ready;
	assign w_beat.data = rd_data;
	assign w_beat.last = w_last;

	assign b_ready = (state == vdma_axi_pkg::st_resp);

endmodule

`default_nettype wire

//--- rtl/line_fifo.sv
/*
 * Synchronous line FIFO with valid/ready on both ports
 * and a registered fill count
 */
`timescale 1ns/1ns
`default_nettype none
`include "vdma_macros.svh"

module line_fifo #(
	parameter int DEPTH = `VDMA_FIFO_DEPTH
) (
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,
	input wire vdma_frame_pkg::pixel_word_t in_data,
	input wire in_valid,
	output logic in_ready,
	output vdma_frame_pkg::pixel_word_t out_data,
	output logic out_valid,
	input wire out_ready,
	output logic [$clog2(DEPTH+1)-1:0] count
);

	localparam int PTR_W = $clog2(DEPTH);

	vdma_frame_pkg::pixel_word_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic push;
	logic pop;

	assign in_ready = (count != DEPTH[$clog2(DEPTH+1)-1:0]);
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	// Word storage
	always_ff @(posedge M_AXI_ACLK) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count unchanged
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/stream_demux.sv
/*
 * Input stream demultiplexer
 * Steers each beat to the line FIFO of its channel
 */
`timescale 1ns/1ns
`default_nettype none
`include "vdma_macros.svh"

module stream_demux (
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,
	input wire vdma_frame_pkg::pix_beat_t pix_in,
	input wire pix_valid,
	output logic pix_ready,
	output vdma_frame_pkg::pixel_word_t fifo_in_data,
	output logic [`VDMA_CHANNELS-1:0] fifo_in_valid,
	input wire [`VDMA_CHANNELS-1:0] fifo_in_ready
);

	// Data fans out to all FIFOs, only one sees valid
	assign fifo_in_data = pix_in.data;

	// A full FIFO stalls only beats aimed at it
	assign pix_ready = fifo_in_ready[pix_in.chan];

	always_comb begin
		for (int c = 0; c < `VDMA_CHANNELS; c++) begin
			fifo_in_valid[c] = pix_valid && (pix_in.chan == vdma_frame_pkg::chan_id_t'(c));
		end
	end

endmodule

`default_nettype wire

//--- rtl/vdma_axi_pkg.sv
/*
 * AXI write-side types: address, AWLEN, AW request, W beat,
 * B response and the frame writer state machine
 */
`default_nettype none
`include "vdma_macros.svh"

package vdma_axi_pkg;

	typedef logic [`VDMA_ADDR_W-1:0] axi_addr_t;

	// AWLEN holds beats minus one
	typedef logic [7:0] burst_len_t;

	typedef struct packed {
		axi_addr_t addr;
		burst_len_t len;
	} aw_req_t;

	typedef struct packed {
		logic [`VDMA_DATA_W-1:0] data;
		logic last;
	} w_beat_t;

	// OKAY, EXOKAY, SLVERR, DECERR
	typedef logic [1:0] b_resp_t;

	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_data,
		st_resp
	} writer_state_t;

endpackage

`default_nettype wire

//--- rtl/vdma_frame_pkg.sv
/*
 * Image-side types: pixel word, dimensions, channel number,
 * per-channel frame configuration and the shared input beat
 */
`default_nettype none
`include "vdma_macros.svh"

package vdma_frame_pkg;

	// Pixel 0 sits in the low byte
	typedef logic [`VDMA_DATA_W-1:0] pixel_word_t;
	typedef logic [`VDMA_DIM_W-1:0] img_dim_t;
	typedef logic [$clog2(`VDMA_CHANNELS)-1:0] chan_id_t;

	// Base and stride are byte values, width and height are pixels
	typedef struct packed {
		logic [`VDMA_ADDR_W-1:0] base;
		logic [`VDMA_ADDR_W-1:0] stride;
		img_dim_t width;
		img_dim_t height;
	} frame_cfg_t;

	typedef struct packed {
		chan_id_t chan;
		pixel_word_t data;
	} pix_beat_t;

endpackage

`default_nettype wire

//--- rtl/vdma_macros.svh
/*
 * Global sizing for the video frame writer
 * Channel count, burst length, bus widths, pixel packing, FIFO depth
 */
`ifndef VDMA_MACROS_SVH
`define VDMA_MACROS_SVH

// Number of independent pixel channels
`define VDMA_CHANNELS 2

// Beats in a full AXI burst
`define VDMA_BURST_LEN 16

// AXI bus widths
`define VDMA_DATA_W 32
`define VDMA_ADDR_W 32

// Four 8-bit pixels share one data word
`define VDMA_PIX_PER_WORD 4

// Line FIFO entries per channel
`define VDMA_FIFO_DEPTH 64

// Width and height fields, in pixels
`define VDMA_DIM_W 12

`endif
